/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// datapath widths fixed by the instruction format
	localparam int DATA_W     = 16;
	localparam int INSTR_W    = 16;
	localparam int PC_W       = 8;
	localparam int REG_ADDR_W = 3;
	localparam int NUM_REGS   = 8;

	// flags word layout
	localparam int FLAG_Z = 0; // zero
	localparam int FLAG_C = 1; // carry / borrow
	localparam int FLAG_S = 2; // sign
	localparam int FLAG_O = 3; // signed overflow

	// opcodes, instr[15:12]
	localparam logic [3:0] OP_ADD = 4'b0000;
	localparam logic [3:0] OP_SUB = 4'b0001;
	localparam logic [3:0] OP_AND = 4'b0010;
	localparam logic [3:0] OP_OR  = 4'b0011;
	localparam logic [3:0] OP_XOR = 4'b0100;
	localparam logic [3:0] OP_SHL = 4'b0101;
	localparam logic [3:0] OP_LDI = 4'b0110;
	localparam logic [3:0] OP_JT  = 4'b1000; // jump if true
	localparam logic [3:0] OP_JF  = 4'b1001; // jump if false
	localparam logic [3:0] OP_JMP = 4'b1010;
	localparam logic [3:0] OP_NOP = 4'b1111;

	// branch condition codes
	localparam logic [3:0] COND_NOT_ZERO = 4'b0000;
	localparam logic [3:0] COND_OVF      = 4'b0011;
	localparam logic [3:0] COND_NEG      = 4'b0100;
	localparam logic [3:0] COND_ZERO     = 4'b0101;
	localparam logic [3:0] COND_CARRY    = 4'b0110;
	localparam logic [3:0] COND_NEG_ZERO = 4'b0111;
	localparam logic [3:0] COND_ALWAYS   = 4'b1100; // unconditional jumps
	localparam logic [3:0] COND_NONE     = 4'b1111; // never taken

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_SHL  = 3'd5,
		ALU_PASS = 3'd6  // immediate pass-through
	} alu_op_e;

endpackage

`default_nettype wire

/* rtl/instr_decode.sv */
`default_nettype none

module instr_decode import cpu_pkg::*; (
	input  wire logic [INSTR_W-1:0]    instr,
	output logic      [REG_ADDR_W-1:0] rd_addr,
	output logic      [REG_ADDR_W-1:0] rs1_addr,
	output logic      [REG_ADDR_W-1:0] rs2_addr,
	output alu_op_e                    alu_op,
	output logic                       use_imm,
	output logic      [DATA_W-1:0]     imm,
	output logic                       writes_reg,
	output logic                       writes_flags,
	output logic      [3:0]            condicao,
	output logic                       opcode,
	output logic      [PC_W-1:0]       target
);

	logic [3:0] op;

	assign op = instr[15:12];

	// fixed fields whose meaning depends on the opcode
	assign rd_addr  = instr[11:9];
	assign rs1_addr = instr[8:6];
	assign rs2_addr = instr[5:3];
	assign imm      = {{(DATA_W-8){1'b0}}, instr[7:0]}; // zero-extended
	assign target   = instr[PC_W-1:0];

	always_comb begin
		alu_op       = ALU_PASS;
		use_imm      = 1'b0;
		writes_reg   = 1'b0;
		writes_flags = 1'b0;
		condicao     = COND_NONE; // no branch unless a jump
		opcode       = 1'b0;

		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL: begin
				writes_reg   = 1'b1;
				writes_flags = 1'b1;
				case (op)
					OP_ADD:  alu_op = ALU_ADD;
					OP_SUB:  alu_op = ALU_SUB;
					OP_AND:  alu_op = ALU_AND;
					OP_OR:   alu_op = ALU_OR;
					OP_XOR:  alu_op = ALU_XOR;
					default: alu_op = ALU_SHL;
				endcase
			end
			OP_LDI: begin
				alu_op     = ALU_PASS;
				use_imm    = 1'b1;
				writes_reg = 1'b1; // flags untouched
			end
			OP_JT: begin
				condicao = instr[11:8];
				opcode   = 1'b1; // jtrue
			end
			OP_JF: begin
				condicao = instr[11:8];
				opcode   = 1'b0; // jfalse
			end
			OP_JMP: begin
				condicao = COND_ALWAYS;
				opcode   = 1'b1;
			end
			default: begin
				// nop and unused opcodes only advance the pc
				condicao = COND_NONE;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file import cpu_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  arst_n,
	input  wire logic [REG_ADDR_W-1:0] rs1_addr,
	input  wire logic [REG_ADDR_W-1:0] rs2_addr,
	input  wire logic [REG_ADDR_W-1:0] wr_addr,
	input  wire logic                  wr_en,
	input  wire logic [DATA_W-1:0]     wr_data,
	output logic      [DATA_W-1:0]     rs1_data,
	output logic      [DATA_W-1:0]     rs2_data
);

	logic [DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// reads see the state left by the previous instruction
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

module alu import cpu_pkg::*; (
	input  alu_op_e                alu_op,
	input  wire logic [DATA_W-1:0] a,
	input  wire logic [DATA_W-1:0] b,
	input  wire logic [DATA_W-1:0] imm,
	input  wire logic              use_imm,
	output logic      [DATA_W-1:0] result,
	output logic      [3:0]        flags_next
);

	logic [DATA_W-1:0] operand; // second operand after the immediate mux
	logic [DATA_W:0]   sum;
	logic [DATA_W:0]   diff;
	logic              carry;
	logic              ovf;

	assign operand = use_imm ? imm : b;

	// one extra bit catches carry out and borrow
	assign sum  = {1'b0, a} + {1'b0, operand};
	assign diff = {1'b0, a} - {1'b0, operand};

	always_comb begin
		result = '0;
		carry  = 1'b0;
		ovf    = 1'b0;

		case (alu_op)
			ALU_ADD: begin
				result = sum[DATA_W-1:0];
				carry  = sum[DATA_W];
				// same-sign inputs whose sum flips sign
				ovf    = (a[DATA_W-1] == operand[DATA_W-1]) &&
				         (result[DATA_W-1] != a[DATA_W-1]);
			end
			ALU_SUB: begin
				result = diff[DATA_W-1:0];
				carry  = diff[DATA_W]; // borrow
				ovf    = (a[DATA_W-1] != operand[DATA_W-1]) &&
				         (result[DATA_W-1] != a[DATA_W-1]);
			end
			ALU_AND: result = a & operand;
			ALU_OR:  result = a | operand;
			ALU_XOR: result = a ^ operand;
			ALU_SHL: begin
				result = {a[DATA_W-2:0], 1'b0};
				carry  = a[DATA_W-1]; // bit shifted out
			end
			ALU_PASS: result = operand;
			default:  result = '0;
		endcase
	end

	always_comb begin
		flags_next         = '0;
		flags_next[FLAG_Z] = (result == '0);
		flags_next[FLAG_C] = carry;
		flags_next[FLAG_S] = result[DATA_W-1];
		flags_next[FLAG_O] = ovf;
	end

endmodule

`default_nettype wire

/* rtl/test_flags.sv */
`default_nettype none

module test_flags import cpu_pkg::*; (
	input  wire logic       opcode,   // 1 = jtrue, 0 = jfalse
	input  wire logic [3:0] condicao,
	input  wire logic [3:0] flags,
	output logic            saida_mux // take the branch
);

	logic hit; // selected condition holds

	always_comb begin
		hit = 1'b0;
		case (condicao)
			COND_NEG:      hit = flags[FLAG_S];
			COND_ZERO:     hit = flags[FLAG_Z];
			COND_CARRY:    hit = flags[FLAG_C];
			COND_NEG_ZERO: hit = flags[FLAG_Z] || flags[FLAG_S];
			COND_NOT_ZERO: hit = !flags[FLAG_Z];
			COND_OVF:      hit = flags[FLAG_O];
			default:       hit = 1'b0;
		endcase
	end

	always_comb begin
		case (condicao)
			COND_NEG, COND_ZERO, COND_CARRY, COND_NEG_ZERO,
			COND_NOT_ZERO, COND_OVF: begin
				saida_mux = opcode ? hit : !hit; // jfalse inverts
			end
			COND_ALWAYS: begin
				saida_mux = 1'b1; // jmp
			end
			default: begin
				saida_mux = 1'b0; // none and unlisted codes never jump
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/retire_unit.sv */
`default_nettype none

module retire_unit import cpu_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  arst_n,
	input  wire logic                  instr_valid,
	input  wire logic                  writes_reg,
	input  wire logic                  writes_flags,
	input  wire logic [3:0]            flags_next,
	input  wire logic                  take_branch,
	input  wire logic [PC_W-1:0]       target,
	input  wire logic [REG_ADDR_W-1:0] rd_addr,
	input  wire logic [DATA_W-1:0]     result,
	output logic                       retire,
	output logic      [PC_W-1:0]       pc,
	output logic      [3:0]            flags,
	output logic                       wr_en,
	output logic      [REG_ADDR_W-1:0] wr_addr,
	output logic      [DATA_W-1:0]     wr_data
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			retire  <= 1'b0;
			pc      <= '0;
			flags   <= '0;
			wr_en   <= 1'b0;
			wr_addr <= '0;
			wr_data <= '0;
		end else if (instr_valid) begin
			retire  <= 1'b1;
			pc      <= take_branch ? target : pc + 1'b1; // wraps at ff
			if (writes_flags) begin
				flags <= flags_next;
			end
			wr_en   <= writes_reg;
			wr_addr <= writes_reg ? rd_addr : '0; // zero when nothing written
			wr_data <= writes_reg ? result : '0;
		end else begin
			retire <= 1'b0; // one pulse per accepted instr
			wr_en  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/cpu_core.sv */
`default_nettype none

module cpu_core import cpu_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  arst_n,
	input  wire logic                  instr_valid,
	input  wire logic [INSTR_W-1:0]    instr,
	output logic                       retire,
	output logic      [PC_W-1:0]       pc,
	output logic      [3:0]            flags,
	output logic                       wr_en,
	output logic      [REG_ADDR_W-1:0] wr_addr,
	output logic      [DATA_W-1:0]     wr_data
);

	logic [REG_ADDR_W-1:0] rd_addr;
	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	alu_op_e               alu_op;
	logic                  use_imm;
	logic [DATA_W-1:0]     imm;
	logic                  writes_reg;
	logic                  writes_flags;
	logic [3:0]            condicao;
	logic                  opcode;
	logic [PC_W-1:0]       target;
	logic [DATA_W-1:0]     rs1_data;
	logic [DATA_W-1:0]     rs2_data;
	logic [DATA_W-1:0]     result;
	logic [3:0]            flags_next;
	logic                  take_branch;
	logic                  rf_wr_en;

	assign rf_wr_en = instr_valid && writes_reg; // only accepted instrs write

	instr_decode instr_decode_inst (
		.instr        (instr),
		.rd_addr      (rd_addr),
		.rs1_addr     (rs1_addr),
		.rs2_addr     (rs2_addr),
		.alu_op       (alu_op),
		.use_imm      (use_imm),
		.imm          (imm),
		.writes_reg   (writes_reg),
		.writes_flags (writes_flags),
		.condicao     (condicao),
		.opcode       (opcode),
		.target       (target)
	);

	reg_file reg_file_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.wr_addr  (rd_addr),
		.wr_en    (rf_wr_en),
		.wr_data  (result),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	alu alu_inst (
		.alu_op     (alu_op),
		.a          (rs1_data),
		.b          (rs2_data),
		.imm        (imm),
		.use_imm    (use_imm),
		.result     (result),
		.flags_next (flags_next)
	);

	// branch decision uses the retired flags
	test_flags test_flags_inst (
		.opcode    (opcode),
		.condicao  (condicao),
		.flags     (flags),
		.saida_mux (take_branch)
	);

	retire_unit retire_unit_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr_valid  (instr_valid),
		.writes_reg   (writes_reg),
		.writes_flags (writes_flags),
		.flags_next   (flags_next),
		.take_branch  (take_branch),
		.target       (target),
		.rd_addr      (rd_addr),
		.result       (result),
		.retire       (retire),
		.pc           (pc),
		.flags        (flags),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data)
	);

endmodule

`default_nettype wire

/* tb/tb_cpu_core.sv */
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          NUM_INSTR   = 2000;
	localparam int          CYCLE_LIMIT = 16 + 2 * NUM_INSTR + 200;
	localparam logic [31:0] LFSR_SEED   = 32'h1bf6_55c0;

	typedef struct packed {
		logic [PC_W-1:0]       pc;
		logic [3:0]            flags;
		logic                  wr_en;
		logic [REG_ADDR_W-1:0] wr_addr;
		logic [DATA_W-1:0]     wr_data;
	} exp_t;

	logic                  clk;
	logic                  arst_n;
	logic                  instr_valid;
	logic [INSTR_W-1:0]    instr;
	logic                  retire;
	logic [PC_W-1:0]       pc;
	logic [3:0]            flags;
	logic                  wr_en;
	logic [REG_ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0]     wr_data;

	logic [31:0]       lfsr_state;
	logic [DATA_W-1:0] model_regs [NUM_REGS];
	logic [3:0]        model_flags;
	logic [PC_W-1:0]   model_pc;
	exp_t              exp_q [$]; // one entry per accepted instr
	logic              accepted_q; // previous edge took an instr
	logic [PC_W-1:0]   last_pc;
	logic [3:0]        last_flags;
	int                issued;
	int                checked;
	int                cycles;

	cpu_core cpu_core_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.retire      (retire),
		.pc          (pc),
		.flags       (flags),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "stopped at the first error");
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] enc_alu(input logic [3:0] op, input logic [2:0] rd,
			input logic [2:0] rs1, input logic [2:0] rs2);
		return {op, rd, rs1, rs2, 3'b000};
	endfunction

	function automatic logic [15:0] enc_ldi(input logic [2:0] rd, input logic [7:0] val);
		return {OP_LDI, rd, 1'b0, val};
	endfunction

	function automatic logic [15:0] enc_jump(input logic [3:0] op, input logic [3:0] cond,
			input logic [7:0] tgt);
		return {op, cond, tgt};
	endfunction

	// weighted mix of ldi 4/16, alu 6/16, jt 2/16, jf 2/16, jmp 1/16, nop or unused 1/16
	function automatic logic [15:0] random_instr();
		logic [3:0]  kind;
		logic [11:0] body;
		logic [2:0]  sel;
		kind = 4'(rand_bits(4));
		body = 12'(rand_bits(12));
		sel  = 3'(rand_bits(3));
		if (kind < 4'd4) begin
			return {OP_LDI, body};
		end else if (kind < 4'd10) begin
			return {1'b0, 3'(sel % 6), body};
		end else if (kind < 4'd12) begin
			return {OP_JT, body};
		end else if (kind < 4'd14) begin
			return {OP_JF, body};
		end else if (kind == 4'd14) begin
			return {OP_JMP, body};
		end
		case (sel)
			3'd1, 3'd5: return {4'b0111, body}; // unused opcodes
			3'd2:       return {4'b1011, body};
			3'd3:       return {4'b1100, body};
			3'd4:       return {4'b1110, body};
			default:    return {OP_NOP, body};
		endcase
	endfunction

	function automatic logic cond_holds(input logic [3:0] cond, input logic jtrue,
			input logic [3:0] fl);
		logic hit;
		case (cond)
			COND_NEG:      hit = fl[FLAG_S];
			COND_ZERO:     hit = fl[FLAG_Z];
			COND_CARRY:    hit = fl[FLAG_C];
			COND_NEG_ZERO: hit = fl[FLAG_Z] | fl[FLAG_S];
			COND_NOT_ZERO: hit = ~fl[FLAG_Z];
			COND_OVF:      hit = fl[FLAG_O];
			COND_ALWAYS:   return 1'b1;
			default:       return 1'b0; // never jumps
		endcase
		return jtrue ? hit : ~hit;
	endfunction

	// applies one instr to the model state
	function automatic exp_t predict_retire(input logic [15:0] i);
		logic [3:0]  op;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [3:0]  f;
		logic        wr;
		logic        alu_op;
		logic        taken;
		int          full;
		int          sgn;
		exp_t        e;
		op     = i[15:12];
		a      = model_regs[i[8:6]];
		b      = model_regs[i[5:3]];
		res    = '0;
		f      = model_flags;
		wr     = 1'b0;
		alu_op = 1'b0;
		taken  = 1'b0;
		case (op)
			OP_ADD: begin
				full     = a + b;
				sgn      = $signed(a) + $signed(b);
				res      = full[15:0];
				f[FLAG_C] = full > 65535;
				f[FLAG_O] = sgn > 32767 || sgn < -32768;
				alu_op   = 1'b1;
			end
			OP_SUB: begin
				sgn      = $signed(a) - $signed(b);
				res      = a - b;
				f[FLAG_C] = a < b; // borrow
				f[FLAG_O] = sgn > 32767 || sgn < -32768;
				alu_op   = 1'b1;
			end
			OP_AND, OP_OR, OP_XOR: begin
				res      = (op == OP_AND) ? (a & b) : (op == OP_OR) ? (a | b) : (a ^ b);
				f[FLAG_C] = 1'b0;
				f[FLAG_O] = 1'b0;
				alu_op   = 1'b1;
			end
			OP_SHL: begin
				res      = a << 1;
				f[FLAG_C] = a[15];
				f[FLAG_O] = 1'b0;
				alu_op   = 1'b1;
			end
			OP_LDI: begin
				res = {8'h00, i[7:0]};
				wr  = 1'b1;
			end
			OP_JT:   taken = cond_holds(i[11:8], 1'b1, model_flags);
			OP_JF:   taken = cond_holds(i[11:8], 1'b0, model_flags);
			OP_JMP:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
		if (alu_op) begin
			f[FLAG_Z] = (res == 16'h0000);
			f[FLAG_S] = res[15];
			wr        = 1'b1;
		end
		if (wr) begin
			model_regs[i[11:9]] = res;
		end
		model_flags = f;
		model_pc    = taken ? i[7:0] : model_pc + 8'd1;
		e.pc        = model_pc;
		e.flags     = model_flags;
		e.wr_en     = wr;
		e.wr_addr   = wr ? i[11:9] : 3'd0;
		e.wr_data   = wr ? res : 16'h0000;
		return e;
	endfunction

	task automatic issue(input logic [15:0] i);
		@(posedge clk);
		#1;
		instr       = i;
		instr_valid = 1'b1;
		exp_q.push_back(predict_retire(i));
		issued++;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		instr       = 16'(rand_bits(16)); // junk that the core must ignore
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			accepted_q <= 1'b0;
		end else begin
			accepted_q <= instr_valid;
		end
	end

	// outputs settle after the rising edge and are checked on the falling one
	always @(negedge clk) begin
		exp_t e;
		if (arst_n) begin
			assert (retire == accepted_q)
			else fail_run($sformatf("MISMATCH at %0t: retire got %b expected %b",
				$time, retire, accepted_q));
			if (accepted_q) begin
				e = exp_q.pop_front();
				assert (pc == e.pc)
				else fail_run($sformatf("MISMATCH at %0t: pc got %h expected %h",
					$time, pc, e.pc));
				assert (flags == e.flags)
				else fail_run($sformatf("MISMATCH at %0t: flags got %b expected %b",
					$time, flags, e.flags));
				assert (wr_en == e.wr_en)
				else fail_run($sformatf("MISMATCH at %0t: wr_en got %b expected %b",
					$time, wr_en, e.wr_en));
				assert (wr_addr == e.wr_addr)
				else fail_run($sformatf("MISMATCH at %0t: wr_addr got %0d expected %0d",
					$time, wr_addr, e.wr_addr));
				assert (wr_data == e.wr_data)
				else fail_run($sformatf("MISMATCH at %0t: wr_data got %h expected %h",
					$time, wr_data, e.wr_data));
				last_pc    = e.pc;
				last_flags = e.flags;
				checked++;
			end else begin
				assert (wr_en == 1'b0 && pc == last_pc && flags == last_flags)
				else fail_run($sformatf("MISMATCH at %0t: idle cycle changed state, pc %h flags %b",
					$time, pc, flags));
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			fail_run("the run timed out before all instructions retired");
		end
	end

	initial begin
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		lfsr_state  = LFSR_SEED;
		model_flags = '0;
		model_pc    = '0;
		last_pc     = '0;
		last_flags  = '0;
		issued      = 0;
		checked     = 0;
		cycles      = 0;
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		assert (!retire && !wr_en && pc == '0 && flags == '0 && wr_data == '0)
		else fail_run($sformatf("MISMATCH at %0t: outputs not cleared by reset", $time));

		// edge operands
		issue(enc_ldi(3'd1, 8'h01));
		issue(enc_alu(OP_SUB, 3'd2, 3'd0, 3'd1)); // 0 - 1
		issue(enc_ldi(3'd3, 8'h80));
		repeat (8) issue(enc_alu(OP_SHL, 3'd3, 3'd3, 3'd0)); // up to 8000
		issue(enc_alu(OP_SHL, 3'd4, 3'd3, 3'd0)); // 8000 << 1
		issue(enc_alu(OP_SUB, 3'd5, 3'd3, 3'd1)); // 8000 - 1
		issue(enc_alu(OP_ADD, 3'd6, 3'd5, 3'd1)); // 7fff + 1
		issue(enc_alu(OP_ADD, 3'd7, 3'd2, 3'd1)); // ffff + 1
		issue(enc_alu(OP_AND, 3'd7, 3'd2, 3'd5));
		issue(enc_alu(OP_OR, 3'd7, 3'd3, 3'd5));
		issue(enc_alu(OP_XOR, 3'd7, 3'd2, 3'd2));

		// every condition code under several flag states
		for (int s = 0; s < 4; s++) begin
			case (s)
				0:       issue(enc_alu(OP_ADD, 3'd7, 3'd2, 3'd1)); // z, c
				1:       issue(enc_alu(OP_ADD, 3'd7, 3'd5, 3'd1)); // s, o
				2:       issue(enc_alu(OP_SUB, 3'd7, 3'd0, 3'd1)); // c, s
				default: issue(enc_alu(OP_ADD, 3'd7, 3'd1, 3'd1));
			endcase
			for (int c = 0; c < 16; c++) begin
				issue(enc_jump(OP_JT, 4'(c), 8'(16 * c + s)));
				issue(enc_jump(OP_JF, 4'(c), 8'(16 * c + s + 8)));
			end
		end

		// pc wrap through nop and unused opcodes
		issue(enc_jump(OP_JMP, 4'h0, 8'hfe));
		issue({OP_NOP, 12'h000});
		issue(16'h7abc);
		issue(16'hd123);

		while (issued < NUM_INSTR) begin
			if (rand_bits(2) == 2'd0) begin
				idle_cycle();
			end else begin
				issue(random_instr());
			end
		end
		idle_cycle();

		while (checked < issued) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
rtl/cpu_pkg.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/test_flags.sv
rtl/retire_unit.sv
rtl/cpu_core.sv
tb/tb_cpu_core.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - rtl/cpu_pkg.sv
  - rtl/instr_decode.sv
  - rtl/reg_file.sv
  - rtl/alu.sv
  - rtl/test_flags.sv
  - rtl/retire_unit.sv
  - rtl/cpu_core.sv
  - target: test
    files:
      - tb/tb_cpu_core.sv
